//--- design/calc_isa_pkg.sv
// RV32 integer subset only (ADD SUB AND OR XOR SLT MUL ADDI); the 32-bit word width is fixed
`default_nettype none

package calc_isa_pkg;

  localparam int data_width_c = 32;

  typedef logic [4:0] reg_addr_t;

  // Major opcodes
  localparam logic [6:0] op_reg_c = 7'b0110011;
  localparam logic [6:0] op_imm_c = 7'b0010011;

  localparam logic [2:0] f3_add_c  = 3'b000;
  localparam logic [2:0] f3_sub_c  = 3'b000;
  localparam logic [2:0] f3_and_c  = 3'b111;
  localparam logic [2:0] f3_or_c   = 3'b110;
  localparam logic [2:0] f3_xor_c  = 3'b100;
  localparam logic [2:0] f3_slt_c  = 3'b010;
  localparam logic [2:0] f3_mul_c  = 3'b000;
  localparam logic [2:0] f3_addi_c = 3'b000;

  // ADD, AND, OR, XOR and SLT share the base funct7
  localparam logic [6:0] f7_base_c = 7'b0000000;
  localparam logic [6:0] f7_sub_c  = 7'b0100000;
  localparam logic [6:0] f7_mul_c  = 7'b0000001;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } instr_rtype_s;

  typedef struct packed {
    logic [11:0] imm12;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } instr_itype_s;

  typedef union packed {
    instr_rtype_s r;
    instr_itype_s i;
  } instr_u;

endpackage

`default_nettype wire

//--- design/calc_pipe_pkg.sv
// Packet layouts assume the four-stage completion pipe with ALU results at stage 1 and MUL at 3
`default_nettype none

package calc_pipe_pkg;

  typedef enum logic [2:0] {
    alu_add_e,
    alu_sub_e,
    alu_and_e,
    alu_or_e,
    alu_xor_e,
    alu_slt_e
  } alu_op_e;

  typedef struct packed {
    logic    pipe_int;
    logic    pipe_mul;
    logic    use_imm;
    logic    illegal;
    logic    irf_w_v;
    alu_op_e alu_op;
  } decode_s;

  // queue_v low with v high marks an injection of rs2_data into rd
  typedef struct packed {
    logic                                   v;
    logic                                   queue_v;
    calc_isa_pkg::instr_u                   instr;
    logic [calc_isa_pkg::data_width_c-1:0] rs1_data;
    logic [calc_isa_pkg::data_width_c-1:0] rs2_data;
  } dispatch_pkt_s;

  typedef struct packed {
    dispatch_pkt_s pkt;
    decode_s       decode;
  } reservation_s;

  typedef struct packed {
    logic                                   w_v;
    calc_isa_pkg::reg_addr_t                rd_addr;
    logic [calc_isa_pkg::data_width_c-1:0] data;
  } wb_pkt_s;

  typedef struct packed {
    logic v;
    logic queue_v;
    logic illegal;
  } exc_stage_s;

  typedef struct packed {
    logic instret;
    logic exception;
  } commit_pkt_s;

  // Write state of one stage plus the data on its way into the next stage
  typedef struct packed {
    logic                                   w_v;
    calc_isa_pkg::reg_addr_t                rd_addr;
    logic [calc_isa_pkg::data_width_c-1:0] next_data;
  } fwd_view_s;

  localparam int comp_stages_c      = 4;
  localparam int commit_stage_c     = 3;
  localparam int int_result_stage_c = 1;
  localparam int mul_result_stage_c = 3;

endpackage

`default_nettype wire

//--- design/calc_issue.sv
// No back-pressure; upstream must hold MUL consumers off for three cycles after the MUL
`default_nettype none

module calc_issue
 (input  wire logic                                                    clk_i
  , input  wire logic                                                  reset_i
  , input  wire calc_pipe_pkg::dispatch_pkt_s                          dispatch_i
  , input  wire calc_pipe_pkg::fwd_view_s [calc_pipe_pkg::comp_stages_c-1:0] fwd_i
  , input  wire logic                                                  flush_i
  , output calc_pipe_pkg::reservation_s                                reservation_o
  );

  localparam int dw_lp = calc_isa_pkg::data_width_c;

  calc_isa_pkg::instr_u        instr;
  calc_pipe_pkg::decode_s      decode;
  calc_pipe_pkg::reservation_s res_n;
  logic [dw_lp-1:0]            rs1_byp;
  logic [dw_lp-1:0]            rs2_byp;

  assign instr = dispatch_i.instr;

  always_comb
  begin
    decode = '0;
    decode.alu_op = calc_pipe_pkg::alu_add_e;
    decode.illegal = 1'b1;
    if (instr.r.opcode == calc_isa_pkg::op_reg_c)
    begin
      if (instr.r.funct7 == calc_isa_pkg::f7_base_c)
      begin
        decode.pipe_int = 1'b1;
        decode.illegal = 1'b0;
        case (instr.r.funct3)
          calc_isa_pkg::f3_add_c: decode.alu_op = calc_pipe_pkg::alu_add_e;
          calc_isa_pkg::f3_and_c: decode.alu_op = calc_pipe_pkg::alu_and_e;
          calc_isa_pkg::f3_or_c:  decode.alu_op = calc_pipe_pkg::alu_or_e;
          calc_isa_pkg::f3_xor_c: decode.alu_op = calc_pipe_pkg::alu_xor_e;
          calc_isa_pkg::f3_slt_c: decode.alu_op = calc_pipe_pkg::alu_slt_e;
          default:
          begin
            decode.pipe_int = 1'b0;
            decode.illegal = 1'b1;
          end
        endcase
      end
      else if (instr.r.funct7 == calc_isa_pkg::f7_sub_c
               && instr.r.funct3 == calc_isa_pkg::f3_sub_c)
      begin
        decode.pipe_int = 1'b1;
        decode.illegal = 1'b0;
        decode.alu_op = calc_pipe_pkg::alu_sub_e;
      end
      else if (instr.r.funct7 == calc_isa_pkg::f7_mul_c
               && instr.r.funct3 == calc_isa_pkg::f3_mul_c)
      begin
        decode.pipe_mul = 1'b1;
        decode.illegal = 1'b0;
      end
    end
    else if (instr.i.opcode == calc_isa_pkg::op_imm_c
             && instr.i.funct3 == calc_isa_pkg::f3_addi_c)
    begin
      decode.pipe_int = 1'b1;
      decode.use_imm = 1'b1;
      decode.illegal = 1'b0;
    end
    decode.irf_w_v = ~decode.illegal & (instr.r.rd != '0);
    // Injections run no unit, they only carry the rd payload
    if (!dispatch_i.queue_v)
    begin
      decode = '0;
      decode.irf_w_v = (instr.r.rd != '0);
    end
  end

  // Walk oldest to youngest so the youngest matching stage wins
  always_comb
  begin
    rs1_byp = dispatch_i.rs1_data;
    rs2_byp = dispatch_i.rs2_data;
    for (int i = calc_pipe_pkg::comp_stages_c-1; i >= 0; i--)
    begin
      if (dispatch_i.queue_v && fwd_i[i].w_v && fwd_i[i].rd_addr == instr.r.rs1)
        rs1_byp = fwd_i[i].next_data;
      if (dispatch_i.queue_v && !decode.use_imm && fwd_i[i].w_v
          && fwd_i[i].rd_addr == instr.r.rs2)
        rs2_byp = fwd_i[i].next_data;
    end
  end

  always_comb
  begin
    res_n = '{pkt: dispatch_i, decode: decode};
    res_n.pkt.v = dispatch_i.v & ~flush_i;
    res_n.pkt.rs1_data = rs1_byp;
    res_n.pkt.rs2_data = rs2_byp;
  end

  always_ff @(posedge clk_i)
  begin
    reservation_o <= res_n;
    if (reset_i)
      reservation_o.pkt.v <= 1'b0;
  end

endmodule

`default_nettype wire

//--- design/calc_pipe_int.sv
// Single-cycle ALU; the result is only meaningful while int_v_o is high
`default_nettype none

module calc_pipe_int
 (input  wire calc_pipe_pkg::reservation_s              reservation_i
  , output logic [calc_isa_pkg::data_width_c-1:0]      int_data_o
  , output logic                                        int_v_o
  );

  localparam int dw_lp = calc_isa_pkg::data_width_c;

  logic [11:0]      imm;
  logic [dw_lp-1:0] imm_ext;
  logic [dw_lp-1:0] src_a;
  logic [dw_lp-1:0] src_b;
  logic             slt;

  // Immediate comes through the I-type view of the same word
  assign imm = reservation_i.pkt.instr.i.imm12;
  assign imm_ext = {{(dw_lp-12){imm[11]}}, imm};

  assign src_a = reservation_i.pkt.rs1_data;
  assign src_b = reservation_i.decode.use_imm ? imm_ext : reservation_i.pkt.rs2_data;

  assign slt = $signed(src_a) < $signed(src_b);

  always_comb
  begin
    case (reservation_i.decode.alu_op)
      calc_pipe_pkg::alu_add_e:
        int_data_o = src_a + src_b;
      calc_pipe_pkg::alu_sub_e:
        int_data_o = src_a - src_b;
      calc_pipe_pkg::alu_and_e:
        int_data_o = src_a & src_b;
      calc_pipe_pkg::alu_or_e:
        int_data_o = src_a | src_b;
      calc_pipe_pkg::alu_xor_e:
        int_data_o = src_a ^ src_b;
      calc_pipe_pkg::alu_slt_e:
        int_data_o = {{(dw_lp-1){1'b0}}, slt};
      default:
        int_data_o = '0;
    endcase
  end

  assign int_v_o = reservation_i.pkt.v & reservation_i.decode.pipe_int;

endmodule

`default_nettype wire

//--- design/calc_pipe_mul.sv
// Low 32 bits of the product only; fixed two-register latency, no stall
`default_nettype none

module calc_pipe_mul
 (input  wire logic                                 clk_i
  , input  wire logic                               reset_i
  , input  wire calc_pipe_pkg::reservation_s        reservation_i
  , input  wire logic                               flush_i
  , output logic [calc_isa_pkg::data_width_c-1:0]  mul_data_o
  , output logic                                    mul_v_o
  );

  localparam int dw_lp = calc_isa_pkg::data_width_c;

  logic [dw_lp-1:0] prod_a_r;
  logic [dw_lp-1:0] prod_b_r;
  logic             v_a_r;
  logic             v_b_r;

  always_ff @(posedge clk_i)
  begin
    prod_a_r <= reservation_i.pkt.rs1_data * reservation_i.pkt.rs2_data;
    prod_b_r <= prod_a_r;
  end

  // Each stage keeps its own valid so two multiplies can overlap
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      v_a_r <= 1'b0;
      v_b_r <= 1'b0;
    end
    else
    begin
      v_a_r <= reservation_i.pkt.v & reservation_i.decode.pipe_mul & ~flush_i;
      v_b_r <= v_a_r & ~flush_i;
    end
  end

  assign mul_data_o = prod_b_r;
  assign mul_v_o = v_b_r;

endmodule

`default_nettype wire

//--- design/calc_completion.sv
// Static unit latencies assumed; only one unit may land a result in a given stage per cycle
`default_nettype none

module calc_completion
 (input  wire logic                                                    clk_i
  , input  wire logic                                                  reset_i
  , input  wire calc_pipe_pkg::dispatch_pkt_s                          dispatch_i
  , input  wire calc_pipe_pkg::reservation_s                           reservation_i
  , input  wire logic [calc_isa_pkg::data_width_c-1:0]                 int_data_i
  , input  wire logic                                                  int_v_i
  , input  wire logic [calc_isa_pkg::data_width_c-1:0]                 mul_data_i
  , input  wire logic                                                  mul_v_i
  , output calc_pipe_pkg::fwd_view_s [calc_pipe_pkg::comp_stages_c-1:0] fwd_o
  , output logic                                                       flush_o
  , output calc_pipe_pkg::wb_pkt_s                                     wb_o
  , output calc_pipe_pkg::commit_pkt_s                                 commit_o
  );

  localparam int stages_lp = calc_pipe_pkg::comp_stages_c;
  localparam int commit_lp = calc_pipe_pkg::commit_stage_c;

  // Entry stages_lp of the next-state array is the committing stage leaving the pipe
  calc_pipe_pkg::wb_pkt_s    [stages_lp:0]   comp_n;
  calc_pipe_pkg::wb_pkt_s    [stages_lp-1:0] comp_r;
  calc_pipe_pkg::exc_stage_s [stages_lp-1:0] exc_n;
  calc_pipe_pkg::exc_stage_s [stages_lp-1:0] exc_r;
  logic                                      injection;

  assign injection = dispatch_i.v & ~dispatch_i.queue_v;

  always_comb
  begin
    comp_n[0].w_v = dispatch_i.v & (dispatch_i.instr.r.rd != '0);
    comp_n[0].rd_addr = dispatch_i.instr.r.rd;
    comp_n[0].data = injection ? dispatch_i.rs2_data : '0;
    exc_n[0].v = dispatch_i.v;
    exc_n[0].queue_v = dispatch_i.queue_v;
    exc_n[0].illegal = 1'b0;
    for (int i = 1; i <= stages_lp; i++)
      comp_n[i] = comp_r[i-1];
    for (int i = 1; i < stages_lp; i++)
      exc_n[i] = exc_r[i-1];

    // The reservation shadows stage 0 and settles its write enable and legality
    comp_n[1].w_v = comp_n[1].w_v & reservation_i.decode.irf_w_v;
    exc_n[1].illegal = reservation_i.decode.illegal;

    if (int_v_i)
      comp_n[calc_pipe_pkg::int_result_stage_c].data = int_data_i;
    if (mul_v_i)
      comp_n[calc_pipe_pkg::mul_result_stage_c].data = mul_data_i;

    // Kill everything younger than the excepting instruction
    if (flush_o)
    begin
      for (int i = 0; i < stages_lp; i++)
      begin
        comp_n[i].w_v = 1'b0;
        exc_n[i].v = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    comp_r <= comp_n[stages_lp-1:0];
    exc_r <= exc_n;
    if (reset_i)
    begin
      for (int i = 0; i < stages_lp; i++)
      begin
        comp_r[i].w_v <= 1'b0;
        exc_r[i].v <= 1'b0;
      end
    end
  end

  always_comb
  begin
    for (int i = 0; i < stages_lp; i++)
    begin
      fwd_o[i].w_v = comp_r[i].w_v & exc_r[i].v;
      fwd_o[i].rd_addr = comp_r[i].rd_addr;
      fwd_o[i].next_data = comp_n[i+1].data;
    end
  end

  always_comb
  begin
    wb_o = comp_r[commit_lp];
    wb_o.w_v = comp_r[commit_lp].w_v & exc_r[commit_lp].v;
    commit_o.instret = exc_r[commit_lp].v & ~exc_r[commit_lp].illegal;
    commit_o.exception = exc_r[commit_lp].v & exc_r[commit_lp].queue_v
                         & exc_r[commit_lp].illegal;
  end

  assign flush_o = commit_o.exception;

endmodule

`default_nettype wire

//--- design/calc_top.sv
// Fixed 4-cycle dispatch to commit latency; upstream owns hazard checking, there is no ready
`default_nettype none

module calc_top
 (input  wire logic                            clk_i
  , input  wire logic                          reset_i
  , input  wire calc_pipe_pkg::dispatch_pkt_s  dispatch_i
  , output calc_pipe_pkg::wb_pkt_s             wb_o
  , output calc_pipe_pkg::commit_pkt_s         commit_o
  );

  calc_pipe_pkg::fwd_view_s [calc_pipe_pkg::comp_stages_c-1:0] fwd;
  calc_pipe_pkg::reservation_s                                 reservation;
  logic [calc_isa_pkg::data_width_c-1:0]                       int_data;
  logic [calc_isa_pkg::data_width_c-1:0]                       mul_data;
  logic                                                        int_v;
  logic                                                        mul_v;
  logic                                                        flush;

  calc_issue u_issue
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.dispatch_i(dispatch_i)
    ,.fwd_i(fwd)
    ,.flush_i(flush)
    ,.reservation_o(reservation)
    );

  // Integer pipe, 1 cycle
  calc_pipe_int u_pipe_int
   (.reservation_i(reservation)
    ,.int_data_o(int_data)
    ,.int_v_o(int_v)
    );

  // Multiply pipe, 3 cycles
  calc_pipe_mul u_pipe_mul
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.reservation_i(reservation)
    ,.flush_i(flush)
    ,.mul_data_o(mul_data)
    ,.mul_v_o(mul_v)
    );

  calc_completion u_completion
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.dispatch_i(dispatch_i)
    ,.reservation_i(reservation)
    ,.int_data_i(int_data)
    ,.int_v_i(int_v)
    ,.mul_data_i(mul_data)
    ,.mul_v_i(mul_v)
    ,.fwd_o(fwd)
    ,.flush_o(flush)
    ,.wb_o(wb_o)
    ,.commit_o(commit_o)
    );

endmodule

`default_nettype wire

//--- bench/calc_assert.sv
// Watches only the commit outputs; bound into calc_completion, silent while reset is high
`default_nettype none

module calc_assert
 (input  wire logic                         clk_i
  , input  wire logic                       reset_i
  , input  wire calc_pipe_pkg::wb_pkt_s     wb_i
  , input  wire calc_pipe_pkg::commit_pkt_s commit_i
  );

  // Number of assertion failures so far
  int fail_count = 0;

  // An excepting instruction neither retires nor writes a register
  a_commit_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(commit_i.exception && (commit_i.instret || wb_i.w_v)))
    else
    begin
      fail_count++;
      $error("exception together with instret or a register write");
    end

  a_write_retires: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_i.w_v |-> commit_i.instret)
    else
    begin
      fail_count++;
      $error("register write without instret");
    end

  // The flush empties everything behind the excepting instruction
  a_flush_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
    commit_i.exception |=> !commit_i.instret && !commit_i.exception && !wb_i.w_v)
    else
    begin
      fail_count++;
      $error("commit activity in the cycle after an exception");
    end

endmodule

`default_nettype wire

//--- bench/calc_tb.sv
// Reads bench/calc_golden.txt from the project root; outputs checked one cycle after each drive
`default_nettype none

module calc_tb;

  localparam int cols_lp = 10;
  localparam int max_rows_lp = 64;
  localparam int reset_cycles_lp = 16;
  // First column value that closes the table
  localparam logic [31:0] end_marker_lp = 32'd2;

  logic                         clk;
  logic                         reset;
  calc_pipe_pkg::dispatch_pkt_s dispatch;
  calc_pipe_pkg::wb_pkt_s       wb;
  calc_pipe_pkg::commit_pkt_s   commit;

  logic [31:0] golden [0:max_rows_lp*cols_lp-1];
  int          n_rows;
  int          cycle_count;
  int          cycle_limit;

  calc_top u_calc_top
   (.clk_i(clk)
    ,.reset_i(reset)
    ,.dispatch_i(dispatch)
    ,.wb_o(wb)
    ,.commit_o(commit)
    );

  bind calc_completion calc_assert u_calc_assert
   (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.wb_i(wb_o)
    ,.commit_i(commit_o)
    );

  initial
  begin
    clk = 1'b0;
    forever
      #10 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    begin
      $display("%s", reason);
      $display("=== FAIL ===");
      $fatal(1, "run aborted");
    end
  endtask

  task automatic compare_value(input int row, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
    begin
      if (exp !== act)
      begin
        $display("FAIL cycle %0d %s: expected %h, actual %h", row, field, exp, act);
        $display("=== FAIL ===");
        $fatal(1, "stopping at first mismatch");
      end
    end
  endtask

  task automatic drive_row(input int row);
    int base;
    begin
      base = row * cols_lp;
      dispatch.v = golden[base][0];
      dispatch.queue_v = golden[base+1][0];
      dispatch.instr = golden[base+2];
      dispatch.rs1_data = golden[base+3];
      dispatch.rs2_data = golden[base+4];
    end
  endtask

  // Write fields only matter when a write is expected
  task automatic check_row(input int row);
    int base;
    begin
      base = row * cols_lp;
      compare_value(row, "wb.w_v", golden[base+5], {31'b0, wb.w_v});
      if (golden[base+5][0])
      begin
        compare_value(row, "wb.rd_addr", golden[base+6], {27'b0, wb.rd_addr});
        compare_value(row, "wb.data", golden[base+7], wb.data);
      end
      compare_value(row, "commit.instret", golden[base+8], {31'b0, commit.instret});
      compare_value(row, "commit.exception", golden[base+9], {31'b0, commit.exception});
      compare_value(row, "assertion failures", 32'd0,
                    u_calc_top.u_completion.u_calc_assert.fail_count);
    end
  endtask

  // Cycle counter against a limit set once the table length is known
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit)
      abort_run("Timeout: the run did not finish within the expected number of cycles");
  end

  initial
  begin
    reset = 1'b1;
    dispatch = '0;
    cycle_count = 0;
    cycle_limit = 0;
    n_rows = 0;
    $readmemh("bench/calc_golden.txt", golden);
    while (n_rows < max_rows_lp && golden[n_rows*cols_lp] != end_marker_lp)
      n_rows++;
    if (n_rows == 0 || n_rows == max_rows_lp)
      abort_run("The golden file is missing, empty or has no end marker");
    cycle_limit = reset_cycles_lp + n_rows + 32;

    repeat (reset_cycles_lp) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    drive_row(0);
    for (int r = 0; r < n_rows; r++)
    begin
      @(negedge clk);
      check_row(r);
      if (r + 1 < n_rows)
        drive_row(r + 1);
      else
        dispatch = '0;
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/calc_golden.txt
// v queue_v instr rs1_data rs2_data, then expected wb w_v rd data, instret, exception
// Expected columns are the commit outputs after this cycle's edge; first column 2 ends the table
1 1 015A00B3 00000005 00000003 0 00 00000000 0 0
1 1 415A0133 00000010 00000030 0 00 00000000 0 0
1 1 015A71B3 F0F0F0F0 FF00FF00 0 00 00000000 0 0
1 1 015A6233 12340000 00005678 1 01 00000008 1 0
1 1 015A42B3 AAAA5555 FFFF0000 1 02 FFFFFFE0 1 0
1 1 015A2333 FFFFFFFF 00000001 1 03 F000F000 1 0
1 1 015A23B3 00000005 80000000 1 04 12345678 1 0
1 1 FFCA0413 00000010 00000099 1 05 55555555 1 0
1 1 015A04B3 00000100 00000001 1 06 00000001 1 0
1 1 01548533 DEAD0000 00000010 1 07 00000000 1 0
1 1 015485B3 DEAD0000 00000020 1 08 0000000C 1 0
1 1 01548633 DEAD0000 00000030 1 09 00000101 1 0
1 1 015486B3 DEAD0000 00000040 1 0A 00000111 1 0
1 1 001A0713 00001000 00000000 1 0B 00000121 1 0
1 1 002A0713 00002000 00000000 1 0C 00000131 1 0
1 1 00E707B3 0BAD0000 0BAD0000 1 0D 00000141 1 0
1 1 035A0833 00012345 00010001 1 0E 00001001 1 0
1 1 035A08B3 FFFFFFFF 00000003 1 0E 00002002 1 0
0 0 00000000 00000000 00000000 1 0F 00004004 1 0
1 1 01580933 0BAD0000 00000005 1 10 23462345 1 0
1 1 015889B3 0BAD0000 00000004 1 11 FFFFFFFD 1 0
1 0 00000B00 00000000 CAFEF00D 0 00 00000000 0 0
1 1 015B0BB3 0BAD0000 00000001 1 12 2346234A 1 0
1 1 015A0033 00000001 00000002 1 13 00000001 1 0
1 1 01500C33 00000007 00000010 1 16 CAFEF00D 1 0
1 1 FF5A0CB3 00000001 00000001 1 17 CAFEF00E 1 0
1 1 035A0D33 00000002 00000003 0 00 00000000 1 0
1 1 015A0DB3 00000001 00000001 1 18 00000017 1 0
1 1 005A0E13 00000001 00000000 0 00 00000000 0 1
1 0 00000E80 00000000 11111111 0 00 00000000 0 0
1 1 015A0F33 00000040 00000002 0 00 00000000 0 0
1 1 015F0FB3 00000000 00000008 0 00 00000000 0 0
0 0 00000000 00000000 00000000 0 00 00000000 0 0
0 0 00000000 00000000 00000000 1 1E 00000042 1 0
0 0 00000000 00000000 00000000 1 1F 0000004A 1 0
0 0 00000000 00000000 00000000 0 00 00000000 0 0
2 0 00000000 00000000 00000000 0 00 00000000 0 0

//--- flist.f
design/calc_isa_pkg.sv
design/calc_pipe_pkg.sv
design/calc_issue.sv
design/calc_pipe_int.sv
design/calc_pipe_mul.sv
design/calc_completion.sv
design/calc_top.sv
bench/calc_assert.sv
bench/calc_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator; exit status reflects the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module calc_tb -f flist.f \
  --Mdir obj_dir -o calc_sim || { echo "build failed"; exit 1; }

./obj_dir/calc_sim 2>&1 | tee sim.log

grep -q "^=== PASS ===$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
